// ==== Bender.yml ====
package:
  name: dcache

sources:
  - common/cachePkg.sv
  - common/busPkg.sv
  - dcache/dataSram.sv
  - dcache/lineRefill.sv
  - dcache/dcacheCtrl.sv
  - verilog/cacheCsr.sv
  - verilog/dcacheTop.sv
  - target: test
    files:
      - bench/memResponder.sv
      - bench/tbDcache.sv

// ==== bench/memResponder.sv ====
`timescale 1ns/100ps
`default_nettype none

module memResponder (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    rdValid_i,
  input  wire cachePkg::addrT    rdAddr_i,
  output logic                   rdReady_o,
  output cachePkg::wordT         rdData_o,
  output logic                   rdBeat_o,
  output logic                   rdLast_o,
  input  wire                    wrValid_i,
  input  wire cachePkg::addrT    wrAddr_i,
  input  wire cachePkg::lineT    wrData_i,
  output logic                   wrReady_o
);

  // 4 KB backing store, one entry per 64-bit word
  cachePkg::wordT mem [512];

  task automatic serveWrite();
    logic [8:0] base;
    repeat ($urandom_range(3)) @(negedge clk);
    wrReady_o = 1'b1;
    base = {wrAddr_i[11:5], 2'b00};
    for (int k = 0; k < 4; k++) begin
      mem[base + 9'(k)] = wrData_i[k*64 +: 64];
    end
    @(negedge clk);
    wrReady_o = 1'b0;
  endtask

  task automatic serveRead();
    logic [8:0] base;
    repeat ($urandom_range(3)) @(negedge clk);
    rdReady_o = 1'b1;
    base = {rdAddr_i[11:5], 2'b00};
    @(negedge clk);
    rdReady_o = 1'b0;
    // beats in order, with random gaps
    for (int k = 0; k < 4; k++) begin
      repeat ($urandom_range(3)) begin
        rdBeat_o = 1'b0;
        rdLast_o = 1'b0;
        @(negedge clk);
      end
      rdBeat_o = 1'b1;
      rdLast_o = (k == 3);
      rdData_o = mem[base + 9'(k)];
      @(negedge clk);
    end
    rdBeat_o = 1'b0;
    rdLast_o = 1'b0;
  endtask

  initial begin
    // fill mixes the whole word index into both halves
    for (int i = 0; i < 512; i++) begin
      mem[i] = {32'(i) * 32'h9e37_79b1, 32'hc0de_0000 + 32'(i)};
    end
    rdReady_o = 1'b0;
    rdData_o  = '0;
    rdBeat_o  = 1'b0;
    rdLast_o  = 1'b0;
    wrReady_o = 1'b0;
    forever begin
      @(negedge clk);
      if (rst_n && wrValid_i) begin
        serveWrite();
      end else if (rst_n && rdValid_i) begin
        serveRead();
      end
    end
  end

endmodule

`default_nettype wire

// ==== bench/tbDcache.sv ====
`timescale 1ns/100ps
`default_nettype none

module tbDcache;

  localparam int NUM_SETS = 16;
  localparam int NUM_OPS  = 300;
  localparam int LIMIT    = NUM_OPS * 20 + 200;

  typedef struct packed {
    logic           isLoad;
    logic           hit;
    logic [31:0]    cycle;
    cachePkg::wordT data;
  } rspT;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               valid, op, addrOk, dataOk;
  cachePkg::addrT     addr;
  cachePkg::wordT     wrData, rdData;
  cachePkg::maskT     wrMask;
  logic               memRdValid, memRdReady, memRdBeat, memRdLast;
  cachePkg::addrT     memRdAddr, memWrAddr;
  cachePkg::wordT     memRdData;
  logic               memWrValid, memWrReady;
  cachePkg::lineT     memWrData;
  logic               psel, penable, pwrite, pslverr;
  busPkg::apbAddrT    paddr;
  busPkg::apbDataT    pwdata, prdata;

  // reference model of memory and of the tag state
  logic [7:0]         image [4096];
  cachePkg::lineAddrT mTag [2][NUM_SETS];
  logic               mValid [2][NUM_SETS];
  logic               mDirty [2][NUM_SETS];
  logic               mPtr [NUM_SETS];
  rspT                rspQ [$];
  cachePkg::addrT     wbQ [$];
  cachePkg::addrT     fetchQ [$];
  cachePkg::addrT     recent [4];
  rspT                rsp;
  cachePkg::addrT     wbAddr;
  cachePkg::addrT     fetchAddr;
  int                 hitCnt, missCnt, wbCnt, chainCnt;
  int                 mismatchCnt, otherErrCnt;
  logic [31:0]        cycleCnt = '0;
  logic [31:0]        lastAccept = 32'hffff_fff0;

  dcacheTop #(.NUM_SETS(NUM_SETS)) dcacheTop_i (
    .clk, .rst_n, .valid_i(valid), .op_i(op), .addr_i(addr), .wrData_i(wrData),
    .wrMask_i(wrMask), .addrOk_o(addrOk), .dataOk_o(dataOk), .rdData_o(rdData),
    .memRdValid_o(memRdValid), .memRdAddr_o(memRdAddr), .memRdReady_i(memRdReady),
    .memRdData_i(memRdData), .memRdBeat_i(memRdBeat), .memRdLast_i(memRdLast),
    .memWrValid_o(memWrValid), .memWrAddr_o(memWrAddr), .memWrData_o(memWrData),
    .memWrReady_i(memWrReady), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
    .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata), .pslverr_o(pslverr)
  );

  memResponder memResp (
    .clk, .rst_n, .rdValid_i(memRdValid), .rdAddr_i(memRdAddr), .rdReady_o(memRdReady),
    .rdData_o(memRdData), .rdBeat_o(memRdBeat), .rdLast_o(memRdLast),
    .wrValid_i(memWrValid), .wrAddr_i(memWrAddr), .wrData_i(memWrData),
    .wrReady_o(memWrReady)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt >= LIMIT) begin
      $display("timeout after %0d cycles, the cache stopped responding", cycleCnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic checkEq(input logic [255:0] got, input logic [255:0] exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
      mismatchCnt++;
    end
  endtask

  task automatic reportFailure(input string msg);
    $display("Error at %0t: %s", $time, msg);
    otherErrCnt++;
  endtask

  function automatic cachePkg::wordT readWord(input int base);
    cachePkg::wordT w;
    for (int b = 0; b < 8; b++) begin
      w[b*8 +: 8] = image[base + b];
    end
    return w;
  endfunction

  function automatic cachePkg::lineT imageLine(input cachePkg::addrT a);
    cachePkg::lineT l;
    for (int b = 0; b < 32; b++) begin
      l[b*8 +: 8] = image[int'(a[11:5]) * 32 + b];
    end
    return l;
  endfunction

  function automatic cachePkg::addrT randAddr();
    return cachePkg::addrT'($urandom_range(511)) << 3;
  endfunction

  // request order equals service order, so the model advances at acceptance
  task automatic modelAccept(input logic isStore, input cachePkg::addrT a,
                             input cachePkg::wordT d, input cachePkg::maskT m);
    cachePkg::lineAddrT lineA;
    int                 set, hw, v, base;
    logic               hit;
    rspT                r;
    lineA = a[31:5];
    set   = int'(lineA) % NUM_SETS;
    hit   = 1'b0;
    hw    = 0;
    for (int w = 0; w < 2; w++) begin
      if (mValid[w][set] && mTag[w][set] == lineA) begin
        hit = 1'b1;
        hw  = w;
      end
    end
    if (hit) begin
      hitCnt++;
      if (isStore) begin
        mDirty[hw][set] = 1'b1;
      end
    end else begin
      missCnt++;
      v = int'(mPtr[set]);
      if (mValid[v][set] && mDirty[v][set]) begin
        wbQ.push_back({mTag[v][set], 5'b00000});
        wbCnt++;
      end
      fetchQ.push_back({lineA, 5'b00000});
      mTag[v][set]   = lineA;
      mValid[v][set] = 1'b1;
      mDirty[v][set] = isStore;
      mPtr[set]      = !mPtr[set];
    end
    base = int'(a[11:3]) * 8;
    if (isStore) begin
      for (int b = 0; b < 8; b++) begin
        if (m[b]) begin
          image[base + b] = d[b*8 +: 8];
        end
      end
    end
    r.isLoad = !isStore;
    r.hit    = hit;
    r.cycle  = cycleCnt;
    r.data   = readWord(base);
    rspQ.push_back(r);
  endtask

  // called at a falling edge, returns one falling edge after acceptance
  task automatic issueOp(input logic isStore, input cachePkg::addrT a,
                         input cachePkg::wordT d, input cachePkg::maskT m);
    valid  = 1'b1;
    op     = isStore;
    addr   = a;
    wrData = d;
    wrMask = m;
    while (!addrOk) begin
      @(negedge clk);
    end
    if (cycleCnt == lastAccept + 1) begin
      chainCnt++;
    end
    lastAccept = cycleCnt;
    modelAccept(isStore, a, d, m);
    @(negedge clk);
    valid = 1'b0;
  endtask

  task automatic apbWrite(input busPkg::apbAddrT a, input busPkg::apbDataT d);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = a;
    pwdata  = d;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apbRead(input busPkg::apbAddrT a, output busPkg::apbDataT d,
                         output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = a;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    d   = prdata;
    err = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  always @(negedge clk) begin
    if (rst_n && dataOk) begin
      if (rspQ.size() == 0) begin
        reportFailure("dataOk_o raised with no request outstanding");
      end else begin
        rsp = rspQ.pop_front();
        if (rsp.isLoad) begin
          checkEq(rdData, rsp.data, "load data");
        end
        if (rsp.hit) begin
          checkEq(cycleCnt, rsp.cycle + 1, "hit latency cycle");
        end
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n && memWrValid && memWrReady) begin
      if (wbQ.size() == 0) begin
        reportFailure("write-back of a line that the model holds clean or invalid");
      end else begin
        wbAddr = wbQ.pop_front();
        checkEq(memWrAddr, wbAddr, "write-back address");
        checkEq(memWrData, imageLine(wbAddr), "write-back line");
      end
    end
  end

  // every line fetch must belong to a miss in the model
  always @(posedge clk) begin
    if (rst_n && memRdValid && memRdReady) begin
      if (fetchQ.size() == 0) begin
        reportFailure("line fetch issued with no miss outstanding");
      end else begin
        fetchAddr = fetchQ.pop_front();
        checkEq(memRdAddr, fetchAddr, "fetch address");
      end
    end
  end

  initial begin
    int              seedVal;
    logic            isStore;
    cachePkg::addrT  a;
    busPkg::apbDataT rd;
    logic            err;
    seedVal = $urandom(18);
    valid   = 1'b0;
    op      = 1'b0;
    addr    = '0;
    wrData  = '0;
    wrMask  = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    rst_n   = 1'b0;
    for (int s = 0; s < NUM_SETS; s++) begin
      mValid[0][s] = 1'b0;
      mValid[1][s] = 1'b0;
      mDirty[0][s] = 1'b0;
      mDirty[1][s] = 1'b0;
      mPtr[s]      = 1'b0;
    end
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    checkEq(addrOk, 1'b1, "addrOk_o after reset");
    checkEq(dataOk, 1'b0, "dataOk_o after reset");
    checkEq(memRdValid, 1'b0, "memRdValid_o after reset");
    checkEq(memWrValid, 1'b0, "memWrValid_o after reset");
    for (int i = 0; i < 512; i++) begin
      for (int b = 0; b < 8; b++) begin
        image[i*8 + b] = memResp.mem[i][b*8 +: 8];
      end
    end
    apbWrite(busPkg::REG_CTRL, 32'h1);
    for (int i = 0; i < NUM_OPS; i++) begin
      isStore = ($urandom_range(99) < 40);
      // loads often revisit a recent address to get hit chains
      if (!isStore && i >= 4 && $urandom_range(1) == 1) begin
        a = recent[$urandom_range(3)];
      end else begin
        a = randAddr();
      end
      recent[i % 4] = a;
      issueOp(isStore, a, {$urandom, $urandom}, cachePkg::maskT'($urandom));
      if ($urandom_range(3) == 0) begin
        @(negedge clk);
      end
    end
    while (rspQ.size() != 0) begin
      @(negedge clk);
    end
    @(negedge clk);
    apbRead(busPkg::REG_HITS, rd, err);
    checkEq(rd, hitCnt, "hit counter");
    apbRead(busPkg::REG_MISSES, rd, err);
    checkEq(rd, missCnt, "miss counter");
    checkEq(err, 1'b0, "pslverr_o on miss counter read");
    apbRead(busPkg::REG_WRBACKS, rd, err);
    checkEq(rd, wbCnt, "write-back counter");
    apbRead(busPkg::REG_CTRL, rd, err);
    checkEq(rd, 32'h1, "counting enable");
    apbWrite(busPkg::REG_HITS, 32'hffff);
    apbRead(busPkg::REG_HITS, rd, err);
    checkEq(rd, 32'h0, "hit counter after clear");
    apbRead(4'h6, rd, err);
    checkEq(err, 1'b1, "pslverr_o on unmapped offset");
    if (wbQ.size() != 0) begin
      reportFailure("a dirty victim was never written back");
    end
    if (chainCnt == 0) begin
      reportFailure("no back-to-back load hits were exercised");
    end
    $display("errors: %0d mismatches, %0d other failures", mismatchCnt, otherErrCnt);
    if (mismatchCnt == 0 && otherErrCnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== common/busPkg.sv ====
`default_nettype none

package busPkg;

  // apb register port
  typedef logic [3:0]  apbAddrT;
  typedef logic [31:0] apbDataT;

  localparam apbAddrT REG_CTRL    = 4'h0;
  localparam apbAddrT REG_HITS    = 4'h4;
  localparam apbAddrT REG_MISSES  = 4'h8;
  localparam apbAddrT REG_WRBACKS = 4'hC;

  // beat number within a four beat burst
  typedef logic [1:0] beatCntT;

endpackage

`default_nettype wire

// ==== common/cachePkg.sv ====
`default_nettype none

package cachePkg;

  // pipeline and line geometry
  localparam int ADDR_W = 32;
  localparam int XLEN   = 64;
  localparam int BEATS  = 4;
  // byte offset bits inside one line
  localparam int OFF_W  = 5;

  typedef logic [ADDR_W-1:0]         addrT;
  typedef logic [XLEN-1:0]           wordT;
  typedef logic [XLEN/8-1:0]         maskT;
  typedef logic [BEATS*XLEN-1:0]     lineT;
  // full line address doubles as the tag
  typedef logic [ADDR_W-OFF_W-1:0]   lineAddrT;
  typedef logic [BEATS*XLEN/8-1:0]   wayMaskT;

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WRBACK,
    FETCH,
    REFILL,
    INSTALL
  } dcacheStateE;

endpackage

`default_nettype wire

// ==== dcache/dataSram.sv ====
`timescale 1ns/100ps
`default_nettype none

module dataSram #(
  parameter int NUM_SETS = 64
) (
  input  wire                          clk,
  input  wire                          ce_i,
  input  wire                          we_i,
  input  wire [$clog2(NUM_SETS)-1:0]   idx_i,
  input  wire cachePkg::lineT          wrData_i,
  input  wire cachePkg::wayMaskT       byteEn_i,
  output cachePkg::lineT               rdData_o
);

  localparam int BYTES = $bits(cachePkg::wayMaskT);

  cachePkg::lineT mem [NUM_SETS];

  // read data holds until the next read access
  always_ff @(posedge clk) begin
    if (ce_i && we_i) begin
      for (int b = 0; b < BYTES; b++) begin
        if (byteEn_i[b]) begin
          mem[idx_i][b*8 +: 8] <= wrData_i[b*8 +: 8];
        end
      end
    end else if (ce_i) begin
      rdData_o <= mem[idx_i];
    end
  end

endmodule

`default_nettype wire

// ==== dcache/dcacheCtrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcacheCtrl #(
  parameter int NUM_SETS = 64
) (
  input  wire                          clk,
  input  wire                          rst_n,
  // pipeline
  input  wire                          valid_i,
  input  wire                          op_i,
  input  wire cachePkg::addrT          addr_i,
  input  wire cachePkg::wordT          wrData_i,
  input  wire cachePkg::maskT          wrMask_i,
  output logic                         addrOk_o,
  output logic                         dataOk_o,
  output cachePkg::wordT               rdData_o,
  // memory read
  output logic                         memRdValid_o,
  output cachePkg::addrT               memRdAddr_o,
  input  wire                          memRdReady_i,
  input  wire                          memRdBeat_i,
  input  wire                          memRdLast_i,
  // memory write
  output logic                         memWrValid_o,
  output cachePkg::addrT               memWrAddr_o,
  output cachePkg::lineT               memWrData_o,
  input  wire                          memWrReady_i,
  // way memories
  output logic [1:0]                   sramCe_o,
  output logic [1:0]                   sramWe_o,
  output logic [$clog2(NUM_SETS)-1:0]  sramIdx_o,
  output cachePkg::lineT               sramWrData_o,
  output cachePkg::wayMaskT            sramMask_o,
  input  wire cachePkg::lineT          sramRdData0_i,
  input  wire cachePkg::lineT          sramRdData1_i,
  // refill buffer
  output logic                         refillCapture_o,
  output logic                         refillClear_o,
  output busPkg::beatCntT              refillBeat_o,
  output logic                         mergeEn_o,
  output busPkg::beatCntT              mergeOff_o,
  output cachePkg::wordT               mergeData_o,
  output cachePkg::maskT               mergeMask_o,
  input  wire cachePkg::lineT          refillLine_i,
  // events
  output logic                         hitEvt_o,
  output logic                         missEvt_o,
  output logic                         wrbackEvt_o
);

  localparam int IDX_W = $clog2(NUM_SETS);
  localparam int OFF_W = cachePkg::OFF_W;
  localparam int XLEN  = cachePkg::XLEN;

  cachePkg::dcacheStateE state, nextState;

  // latched request
  logic              reqOp;
  cachePkg::addrT    reqAddr;
  cachePkg::wordT    reqData;
  cachePkg::maskT    reqMask;
  logic [IDX_W-1:0]  reqIdx;
  cachePkg::lineAddrT reqLine;
  busPkg::beatCntT   reqWord;

  cachePkg::lineAddrT tagArr [2][NUM_SETS];
  logic [NUM_SETS-1:0] validArr [2];
  logic [NUM_SETS-1:0] dirtyArr [2];
  logic [NUM_SETS-1:0] victimPtr;

  logic [1:0]        wayHit;
  logic              hit, lookupHit, accept;
  logic              victim, victimDirty;
  cachePkg::lineT    hitLine, victimLine;
  busPkg::beatCntT   beatCnt;

  assign reqIdx  = reqAddr[OFF_W +: IDX_W];
  assign reqLine = reqAddr[cachePkg::ADDR_W-1:OFF_W];
  assign reqWord = reqAddr[4:3];

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayHit[w] = validArr[w][reqIdx] && (tagArr[w][reqIdx] == reqLine);
    end
  end

  assign hit       = |wayHit;
  assign lookupHit = (state == cachePkg::LOOKUP) && hit;
  assign accept    = valid_i && addrOk_o;

  assign hitLine     = wayHit[1] ? sramRdData1_i : sramRdData0_i;
  assign victim      = victimPtr[reqIdx];
  assign victimLine  = victim ? sramRdData1_i : sramRdData0_i;
  assign victimDirty = validArr[victim][reqIdx] && dirtyArr[victim][reqIdx];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= cachePkg::IDLE;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      cachePkg::IDLE: begin
        if (valid_i) begin
          nextState = cachePkg::LOOKUP;
        end
      end
      cachePkg::LOOKUP: begin
        if (hit) begin
          // a load hit can chain straight into the next lookup
          nextState = (!reqOp && valid_i) ? cachePkg::LOOKUP : cachePkg::IDLE;
        end else begin
          nextState = victimDirty ? cachePkg::WRBACK : cachePkg::FETCH;
        end
      end
      cachePkg::WRBACK: begin
        if (memWrReady_i) begin
          nextState = cachePkg::FETCH;
        end
      end
      cachePkg::FETCH: begin
        if (memRdReady_i) begin
          nextState = cachePkg::REFILL;
        end
      end
      cachePkg::REFILL: begin
        if (memRdBeat_i && memRdLast_i) begin
          nextState = cachePkg::INSTALL;
        end
      end
      cachePkg::INSTALL: nextState = cachePkg::IDLE;
      default:           nextState = cachePkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqOp   <= op_i;
      reqAddr <= addr_i;
      reqData <= wrData_i;
      reqMask <= wrMask_i;
    end
  end

  assign addrOk_o = (state == cachePkg::IDLE) || (lookupHit && !reqOp);
  assign dataOk_o = lookupHit || (state == cachePkg::INSTALL);
  assign rdData_o = (state == cachePkg::INSTALL) ? refillLine_i[reqWord*XLEN +: XLEN]
                                                 : hitLine[reqWord*XLEN +: XLEN];

  assign memWrValid_o = (state == cachePkg::WRBACK);
  assign memWrAddr_o  = {tagArr[victim][reqIdx], {OFF_W{1'b0}}};
  assign memWrData_o  = victimLine;
  assign memRdValid_o = (state == cachePkg::FETCH);
  assign memRdAddr_o  = {reqLine, {OFF_W{1'b0}}};

  // store hit writes the hit way, install writes the victim way
  always_comb begin
    sramWe_o = '0;
    if (lookupHit && reqOp) begin
      sramWe_o = wayHit;
    end else if (state == cachePkg::INSTALL) begin
      sramWe_o[victim] = 1'b1;
    end
  end

  assign sramCe_o     = sramWe_o | {2{accept}};
  assign sramIdx_o    = accept ? addr_i[OFF_W +: IDX_W] : reqIdx;
  assign sramWrData_o = (state == cachePkg::INSTALL) ? refillLine_i
                                                     : {cachePkg::BEATS{reqData}};
  assign sramMask_o   = (state == cachePkg::INSTALL) ? '1
                      : cachePkg::wayMaskT'(reqMask) << {reqWord, 3'b000};

  assign refillClear_o   = (state == cachePkg::LOOKUP) && !hit;
  assign refillCapture_o = (state == cachePkg::REFILL) && memRdBeat_i;
  assign refillBeat_o    = beatCnt;
  // store miss bytes land in the buffer together with the last beat
  assign mergeEn_o       = refillCapture_o && memRdLast_i && reqOp;
  assign mergeOff_o      = reqWord;
  assign mergeData_o     = reqData;
  assign mergeMask_o     = reqMask;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (refillClear_o) begin
      beatCnt <= '0;
    end else if (refillCapture_o) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArr  <= '{default: '0};
      dirtyArr  <= '{default: '0};
      victimPtr <= '0;
    end else if (state == cachePkg::INSTALL) begin
      validArr[victim][reqIdx] <= 1'b1;
      dirtyArr[victim][reqIdx] <= reqOp;
      victimPtr[reqIdx]        <= !victim;
    end else if (lookupHit && reqOp) begin
      dirtyArr[wayHit[1]][reqIdx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (state == cachePkg::INSTALL) begin
      tagArr[victim][reqIdx] <= reqLine;
    end
  end

  assign hitEvt_o    = lookupHit;
  assign missEvt_o   = (state == cachePkg::LOOKUP) && !hit;
  assign wrbackEvt_o = (state == cachePkg::WRBACK) && memWrReady_i;

  // write-back request holds address and line until the memory takes it
  memWrHold: assert property (@(posedge clk) disable iff (!rst_n)
    memWrValid_o && !memWrReady_i |=> memWrValid_o && $stable(memWrAddr_o)
      && $stable(memWrData_o));

  wayWeOne: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(sramWe_o));

  // install only after all four beats were captured
  fullRefill: assert property (@(posedge clk) disable iff (!rst_n)
    state == cachePkg::INSTALL |-> beatCnt == '0);

endmodule

`default_nettype wire

// ==== dcache/lineRefill.sv ====
`timescale 1ns/100ps
`default_nettype none

module lineRefill (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    clear_i,
  input  wire                    capture_i,
  input  wire busPkg::beatCntT   beat_i,
  input  wire cachePkg::wordT    beatData_i,
  input  wire                    mergeEn_i,
  input  wire busPkg::beatCntT   mergeOff_i,
  input  wire cachePkg::wordT    mergeData_i,
  input  wire cachePkg::maskT    mergeMask_i,
  output cachePkg::lineT         line_o
);

  localparam int XLEN  = cachePkg::XLEN;
  localparam int WBYTE = XLEN / 8;

  // beats already captured since the last clear
  logic [cachePkg::BEATS-1:0] seenBeats;

  // merge comes after capture so store bytes win over the fetched beat
  always_ff @(posedge clk) begin
    if (capture_i) begin
      line_o[beat_i*XLEN +: XLEN] <= beatData_i;
    end
    if (mergeEn_i) begin
      for (int b = 0; b < WBYTE; b++) begin
        if (mergeMask_i[b]) begin
          line_o[mergeOff_i*XLEN + b*8 +: 8] <= mergeData_i[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seenBeats <= '0;
    end else if (clear_i) begin
      seenBeats <= '0;
    end else if (capture_i) begin
      seenBeats[beat_i] <= 1'b1;
    end
  end

  // each slot filled once per refill
  beatOnce: assert property (@(posedge clk) disable iff (!rst_n)
    capture_i && !clear_i |-> !seenBeats[beat_i]);

endmodule

`default_nettype wire

// ==== src.f ====
common/cachePkg.sv
common/busPkg.sv
dcache/dataSram.sv
dcache/lineRefill.sv
dcache/dcacheCtrl.sv
verilog/cacheCsr.sv
verilog/dcacheTop.sv
bench/memResponder.sv
bench/tbDcache.sv

// ==== verilog/cacheCsr.sv ====
`timescale 1ns/100ps
`default_nettype none

module cacheCsr (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    psel_i,
  input  wire                    penable_i,
  input  wire                    pwrite_i,
  input  wire busPkg::apbAddrT   paddr_i,
  input  wire busPkg::apbDataT   pwdata_i,
  output busPkg::apbDataT        prdata_o,
  output logic                   pslverr_o,
  input  wire                    hitEvt_i,
  input  wire                    missEvt_i,
  input  wire                    wrbackEvt_i
);

  logic             access, wrAccess, regHit, countEn;
  logic [2:0]       evt, clr;
  // 0 hits, 1 misses, 2 write-backs
  busPkg::apbDataT  counter [3];

  assign access   = psel_i && penable_i;
  assign wrAccess = access && pwrite_i;
  assign evt      = {wrbackEvt_i, missEvt_i, hitEvt_i};

  always_comb begin
    regHit   = 1'b1;
    prdata_o = '0;
    clr      = '0;
    case (paddr_i)
      busPkg::REG_CTRL:    prdata_o = busPkg::apbDataT'(countEn);
      busPkg::REG_HITS: begin
        prdata_o = counter[0];
        clr[0]   = wrAccess;
      end
      busPkg::REG_MISSES: begin
        prdata_o = counter[1];
        clr[1]   = wrAccess;
      end
      busPkg::REG_WRBACKS: begin
        prdata_o = counter[2];
        clr[2]   = wrAccess;
      end
      default: regHit = 1'b0;
    endcase
  end

  assign pslverr_o = access && !regHit;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      countEn <= 1'b0;
    end else if (wrAccess && paddr_i == busPkg::REG_CTRL) begin
      countEn <= pwdata_i[0];
    end
  end

  // counters stick at all ones
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      counter <= '{default: '0};
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (clr[i]) begin
          counter[i] <= '0;
        end else if (countEn && evt[i] && counter[i] != '1) begin
          counter[i] <= counter[i] + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dcacheTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcacheTop #(
  parameter int NUM_SETS = 64
) (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    valid_i,
  input  wire                    op_i,
  input  wire cachePkg::addrT    addr_i,
  input  wire cachePkg::wordT    wrData_i,
  input  wire cachePkg::maskT    wrMask_i,
  output logic                   addrOk_o,
  output logic                   dataOk_o,
  output cachePkg::wordT         rdData_o,
  output logic                   memRdValid_o,
  output cachePkg::addrT         memRdAddr_o,
  input  wire                    memRdReady_i,
  input  wire cachePkg::wordT    memRdData_i,
  input  wire                    memRdBeat_i,
  input  wire                    memRdLast_i,
  output logic                   memWrValid_o,
  output cachePkg::addrT         memWrAddr_o,
  output cachePkg::lineT         memWrData_o,
  input  wire                    memWrReady_i,
  input  wire                    psel_i,
  input  wire                    penable_i,
  input  wire                    pwrite_i,
  input  wire busPkg::apbAddrT   paddr_i,
  input  wire busPkg::apbDataT   pwdata_i,
  output busPkg::apbDataT        prdata_o,
  output logic                   pslverr_o
);

  localparam int IDX_W = $clog2(NUM_SETS);

  logic [1:0]          sramCe, sramWe;
  logic [IDX_W-1:0]    sramIdx;
  cachePkg::lineT      sramWrData, sramRdData0, sramRdData1, refillLine;
  cachePkg::wayMaskT   sramMask;
  logic                refillCapture, refillClear, mergeEn;
  busPkg::beatCntT     refillBeat, mergeOff;
  cachePkg::wordT      mergeData;
  cachePkg::maskT      mergeMask;
  logic                hitEvt, missEvt, wrbackEvt;

  dcacheCtrl #(.NUM_SETS(NUM_SETS)) ctrl (
    .clk, .rst_n, .valid_i, .op_i, .addr_i, .wrData_i, .wrMask_i,
    .addrOk_o, .dataOk_o, .rdData_o,
    .memRdValid_o, .memRdAddr_o, .memRdReady_i, .memRdBeat_i, .memRdLast_i,
    .memWrValid_o, .memWrAddr_o, .memWrData_o, .memWrReady_i,
    .sramCe_o(sramCe), .sramWe_o(sramWe), .sramIdx_o(sramIdx),
    .sramWrData_o(sramWrData), .sramMask_o(sramMask),
    .sramRdData0_i(sramRdData0), .sramRdData1_i(sramRdData1),
    .refillCapture_o(refillCapture), .refillClear_o(refillClear),
    .refillBeat_o(refillBeat), .mergeEn_o(mergeEn), .mergeOff_o(mergeOff),
    .mergeData_o(mergeData), .mergeMask_o(mergeMask), .refillLine_i(refillLine),
    .hitEvt_o(hitEvt), .missEvt_o(missEvt), .wrbackEvt_o(wrbackEvt)
  );

  dataSram #(.NUM_SETS(NUM_SETS)) way0 (
    .clk, .ce_i(sramCe[0]), .we_i(sramWe[0]), .idx_i(sramIdx),
    .wrData_i(sramWrData), .byteEn_i(sramMask), .rdData_o(sramRdData0)
  );

  dataSram #(.NUM_SETS(NUM_SETS)) way1 (
    .clk, .ce_i(sramCe[1]), .we_i(sramWe[1]), .idx_i(sramIdx),
    .wrData_i(sramWrData), .byteEn_i(sramMask), .rdData_o(sramRdData1)
  );

  lineRefill refill (
    .clk, .rst_n, .clear_i(refillClear), .capture_i(refillCapture),
    .beat_i(refillBeat), .beatData_i(memRdData_i),
    .mergeEn_i(mergeEn), .mergeOff_i(mergeOff), .mergeData_i(mergeData),
    .mergeMask_i(mergeMask), .line_o(refillLine)
  );

  cacheCsr csr (
    .clk, .rst_n, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pslverr_o,
    .hitEvt_i(hitEvt), .missEvt_i(missEvt), .wrbackEvt_i(wrbackEvt)
  );

endmodule

`default_nettype wire
